/* rtl/immu_pkg.sv */
package immu_pkg;

	// Address and page geometry
	localparam int ADDR_W = 32;
	localparam int PAGE_BITS = 13;
	// 8 KiB pages, direct-mapped ITLB
	localparam int ITLB_SETS = 64;
	localparam int ITLB_IDX_W = $clog2(ITLB_SETS);
	// Tag sits above the set index
	localparam int MR_TAG_LSB = PAGE_BITS + ITLB_IDX_W;
	localparam int VPN_TAG_W = ADDR_W - MR_TAG_LSB;
	localparam int PPN_W = ADDR_W - PAGE_BITS;

	// Fetch address after reset
	localparam logic [ADDR_W-1:0] BOOT_ADR = 32'h0000_0100;

	// SPR map, set number in the low address bits
	localparam logic [ADDR_W-1:0] SPR_ITLB_MR_BASE = 32'h0000_1200;
	localparam logic [ADDR_W-1:0] SPR_ITLB_TR_BASE = 32'h0000_1300;
	// Address bit telling translate from match registers
	localparam int SPR_SEL_TR_BIT = 8;

	// Match register layout
	localparam int MR_V_BIT = 0;
	// Translate register layout
	localparam int TR_PPN_LSB = PAGE_BITS;
	localparam int TR_UXE_BIT = 7;
	localparam int TR_SXE_BIT = 6;
	localparam int TR_CI_BIT = 1;

	// Cache inhibit with translation off
	localparam logic IMMU_CI_DEFAULT = 1'b0;

	// Fetch tags, memory-side tags pass through as plain values
	typedef enum logic [3:0] {
		ITAG_NONE = 4'h0,
		ITAG_TE   = 4'hA,
		ITAG_PE   = 4'hB
	} itag_e;

	// SPR bus request as seen by the IMMU
	typedef struct packed {
		logic              cs;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [31:0]       wdata;
	} spr_req_t;

	// One ITLB lookup result
	typedef struct packed {
		logic             hit;
		logic [PPN_W-1:0] ppn;
		logic             uxe;
		logic             sxe;
		logic             ci;
	} itlb_xlate_t;

endpackage

/* rtl/immu_itlb.sv */
`timescale 1ns/100ps

module immu_itlb (
	input  logic                          clk,
	input  logic                          dis_spr_access_frst_clk,
	input  logic                          lookup_en_i,
	input  logic [immu_pkg::ADDR_W-1:0]   vaddr_i,
	input  immu_pkg::spr_req_t            spr_i,
	output logic [31:0]                   spr_dat_o,
	output immu_pkg::itlb_xlate_t         xlate_o
);
	import immu_pkg::*;

	// Match array, tag plus valid
	logic [VPN_TAG_W-1:0]  mr_tag [ITLB_SETS];
	logic [ITLB_SETS-1:0]  mr_valid;
	// Translate array
	logic [PPN_W-1:0]      tr_ppn [ITLB_SETS];
	logic [ITLB_SETS-1:0]  tr_uxe;
	logic [ITLB_SETS-1:0]  tr_sxe;
	logic [ITLB_SETS-1:0]  tr_ci;

	logic [ITLB_IDX_W-1:0] spr_idx;
	logic                  spr_sel_tr;
	logic                  spr_wr;
	logic [ITLB_IDX_W-1:0] lkp_idx;
	// Registered read side
	logic [ITLB_IDX_W-1:0] idx_q;
	logic [VPN_TAG_W-1:0]  vtag_q;
	logic                  sel_tr_q;
	logic                  lookup_q;

	// SPR set number and register select
	assign spr_idx = spr_i.addr[ITLB_IDX_W-1:0];
	assign spr_sel_tr = spr_i.addr[SPR_SEL_TR_BIT];
	assign spr_wr = spr_i.cs & spr_i.write;
	// Lookup set from virtual bits 18:13
	assign lkp_idx = vaddr_i[PAGE_BITS +: ITLB_IDX_W];

	// Index register, SPR access wins over lookup
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk) begin
			idx_q <= '0;
			sel_tr_q <= 1'b0;
			lookup_q <= 1'b0;
		end else begin
			lookup_q <= lookup_en_i & ~spr_i.cs;
			if (spr_i.cs) begin
				idx_q <= spr_idx;
				sel_tr_q <= spr_sel_tr;
			end else if (lookup_en_i) begin
				idx_q <= lkp_idx;
			end
		end
	end

	// Virtual tag for the compare one clock later
	always_ff @(posedge clk) begin
		if (lookup_en_i & ~spr_i.cs)
			vtag_q <= vaddr_i[MR_TAG_LSB +: VPN_TAG_W];
	end

	// Valid bits, the only array state that resets
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk)
			mr_valid <= '0;
		else if (spr_wr & ~spr_sel_tr)
			mr_valid[spr_idx] <= spr_i.wdata[MR_V_BIT];
	end

	// mtspr into match or translate entry
	always_ff @(posedge clk) begin
		if (spr_wr) begin
			if (spr_sel_tr) begin
				tr_ppn[spr_idx] <= spr_i.wdata[TR_PPN_LSB +: PPN_W];
				tr_uxe[spr_idx] <= spr_i.wdata[TR_UXE_BIT];
				tr_sxe[spr_idx] <= spr_i.wdata[TR_SXE_BIT];
				tr_ci[spr_idx] <= spr_i.wdata[TR_CI_BIT];
			end else begin
				mr_tag[spr_idx] <= spr_i.wdata[MR_TAG_LSB +: VPN_TAG_W];
			end
		end
	end

	// mfspr word, unimplemented bits read as zero
	always_comb begin
		spr_dat_o = '0;
		if (sel_tr_q) begin
			spr_dat_o[TR_PPN_LSB +: PPN_W] = tr_ppn[idx_q];
			spr_dat_o[TR_UXE_BIT] = tr_uxe[idx_q];
			spr_dat_o[TR_SXE_BIT] = tr_sxe[idx_q];
			spr_dat_o[TR_CI_BIT] = tr_ci[idx_q];
		end else begin
			spr_dat_o[MR_TAG_LSB +: VPN_TAG_W] = mr_tag[idx_q];
			spr_dat_o[MR_V_BIT] = mr_valid[idx_q];
		end
	end

	// Lookup result
	// Hit needs a lookup last clock and a matching valid tag
	always_comb begin
		xlate_o.hit = lookup_q & mr_valid[idx_q] & (mr_tag[idx_q] == vtag_q);
		xlate_o.ppn = tr_ppn[idx_q];
		xlate_o.uxe = tr_uxe[idx_q];
		xlate_o.sxe = tr_sxe[idx_q];
		xlate_o.ci = tr_ci[idx_q];
	end

endmodule

/* rtl/immu_spr_gate.sv */
`timescale 1ns/100ps

module immu_spr_gate (
	input  logic        clk,
	input  logic        dis_spr_access_frst_clk,
	input  logic        spr_cs_i,
	input  logic        icpu_rty_i,
	input  logic [31:0] itlb_dat_i,
	output logic        spr_access_o,
	output logic [31:0] spr_dat_o
);

	// Access finishing markers
	logic        spr_first_clk_q;
	logic        spr_second_clk_q;
	// Held mfspr word
	logic [31:0] spr_rd_q;

	// First clock of access seen while fetch is retrying
	// Dropped retry means the fetch moved on
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk)
			spr_first_clk_q <= 1'b0;
		else if (!icpu_rty_i)
			spr_first_clk_q <= 1'b0;
		else if (spr_cs_i)
			spr_first_clk_q <= 1'b1;
	end

	// Second clock follows the first
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk)
			spr_second_clk_q <= 1'b0;
		else if (!icpu_rty_i)
			spr_second_clk_q <= 1'b0;
		else if (spr_first_clk_q)
			spr_second_clk_q <= 1'b1;
	end

	// ITLB sees cs only until the second marker
	assign spr_access_o = spr_cs_i & ~spr_second_clk_q;

	// Capture ITLB word while the access runs
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk)
			spr_rd_q <= '0;
		else if (spr_access_o)
			spr_rd_q <= itlb_dat_i;
	end

	// Live word during access, held word afterwards
	// keeps mfspr data after the ITLB returns to lookups
	assign spr_dat_o = spr_access_o ? itlb_dat_i : spr_rd_q;

endmodule

/* rtl/immu_top.sv */
`timescale 1ns/100ps

module immu_top (
	input  logic                        clk,
	input  logic                        dis_spr_access_frst_clk,
	// Fetch side
	input  logic                        immu_en_i,
	input  logic                        supv_i,
	input  logic [immu_pkg::ADDR_W-1:0] icpu_adr_i,
	input  logic                        icpu_cycstb_i,
	output logic [immu_pkg::ADDR_W-1:0] icpu_adr_o,
	output immu_pkg::itag_e             icpu_tag_o,
	output logic                        icpu_rty_o,
	output logic                        icpu_err_o,
	output logic                        itlb_uxe_o,
	output logic                        itlb_sxe_o,
	// SPR bus
	input  immu_pkg::spr_req_t          spr_req_i,
	output logic [31:0]                 spr_dat_o,
	// Instruction memory port
	input  logic                        qmem_rty_i,
	input  logic                        qmem_err_i,
	input  logic [3:0]                  qmem_tag_i,
	output logic [immu_pkg::ADDR_W-1:0] qmem_adr_o,
	output logic                        qmem_cycstb_o,
	output logic                        qmem_ci_o
);
	import immu_pkg::*;

	// Boot address path
	logic [ADDR_W-1:0]      icpu_adr_default;
	logic                   icpu_adr_select;
	// Page tracking
	logic [PPN_W-1:0]       icpu_vpn_q;
	logic                   page_cross;
	logic [PAGE_BITS-3:0]   page_off;
	// SPR gating
	logic                   spr_access;
	spr_req_t               spr_gated;
	logic [31:0]            itlb_dat;
	// Lookup control
	itlb_xlate_t            xlate;
	logic                   itlb_en;
	logic                   itlb_en_q;
	logic                   itlb_done;
	// Exceptions
	logic                   miss;
	logic                   fault;
	logic                   xlate_ok;

	// Boot address select
	// Select flop holds boot value through reset and one clock after
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk) begin
			icpu_adr_select <= 1'b1;
		end else if (icpu_adr_select) begin
			icpu_adr_default <= BOOT_ADR;
			icpu_adr_select <= 1'b0;
		end else begin
			// Then the fetch address one clock late
			icpu_adr_default <= icpu_adr_i;
		end
	end

	assign icpu_adr_o = icpu_adr_select ? BOOT_ADR : icpu_adr_default;

	// VPN of previous cycle
	// Also supplies the page when translation is off
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk)
			icpu_vpn_q <= '0;
		else
			icpu_vpn_q <= icpu_adr_i[ADDR_W-1:PAGE_BITS];
	end

	// Page changed since last clock
	assign page_cross = icpu_adr_i[ADDR_W-1:PAGE_BITS] != icpu_vpn_q;

	// Word offset within the page
	assign page_off = icpu_adr_i[PAGE_BITS-1:2];

	// SPR access masking and mfspr data
	immu_spr_gate i_spr_gate (
		.clk                     (clk),
		.dis_spr_access_frst_clk (dis_spr_access_frst_clk),
		.spr_cs_i                (spr_req_i.cs),
		.icpu_rty_i              (icpu_rty_o),
		.itlb_dat_i              (itlb_dat),
		.spr_access_o            (spr_access),
		.spr_dat_o               (spr_dat_o)
	);

	// Request to ITLB with the gated strobe
	always_comb begin
		spr_gated = spr_req_i;
		spr_gated.cs = spr_access;
	end

	// Lookup on every translated fetch request
	assign itlb_en = immu_en_i & icpu_cycstb_i;

	immu_itlb i_itlb (
		.clk                     (clk),
		.dis_spr_access_frst_clk (dis_spr_access_frst_clk),
		.lookup_en_i             (itlb_en),
		.vaddr_i                 (icpu_adr_i),
		.spr_i                   (spr_gated),
		.spr_dat_o               (itlb_dat),
		.xlate_o                 (xlate)
	);

	// Lookup issued last clock without SPR traffic
	always_ff @(posedge clk) begin
		if (dis_spr_access_frst_clk)
			itlb_en_q <= 1'b0;
		else
			itlb_en_q <= itlb_en & ~spr_access;
	end

	// Result only counts on the same page
	assign itlb_done = itlb_en_q & ~page_cross;

	// TLB miss
	assign miss = itlb_done & ~xlate.hit;

	// Page fault when the current mode lacks execute permission
	assign fault = itlb_done & xlate.hit &
		((~supv_i & ~xlate.uxe) | (supv_i & ~xlate.sxe));

	// Permission bits of the looked up entry
	assign itlb_uxe_o = xlate.uxe;
	assign itlb_sxe_o = xlate.sxe;

	// Miss tag wins over fault tag
	always_comb begin
		if (miss)
			icpu_tag_o = ITAG_TE;
		else if (fault)
			icpu_tag_o = ITAG_PE;
		else
			icpu_tag_o = itag_e'(qmem_tag_i);
	end

	// Retry forwarded as is for back-pressure to fetch
	assign icpu_rty_o = qmem_rty_i;

	// Errors from translation or memory
	assign icpu_err_o = miss | fault | qmem_err_i;

	// Translated strobe needs a clean lookup and no SPR access
	assign xlate_ok = ~(miss | fault) & itlb_done & ~spr_access;

	// No strobe on first cycle of a new page
	always_comb begin
		if (immu_en_i)
			qmem_cycstb_o = icpu_cycstb_i & ~page_cross & xlate_ok;
		else
			qmem_cycstb_o = icpu_cycstb_i & ~page_cross;
	end

	// Entry ci when translating
	assign qmem_ci_o = immu_en_i ? xlate.ci : IMMU_CI_DEFAULT;

	// Word aligned physical address
	// Registered VPN when bypassed or lookup not done
	always_comb begin
		if (immu_en_i & itlb_done)
			qmem_adr_o = {xlate.ppn, page_off, 2'b00};
		else
			qmem_adr_o = {icpu_vpn_q, page_off, 2'b00};
	end

endmodule

/* bench/tb_immu_tasks.svh */
`ifndef TB_IMMU_TASKS_SVH
`define TB_IMMU_TASKS_SVH

// LCG step
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
	end
endtask

task automatic check_tag(input string name, input itag_e exp, input itag_e act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic check_xlate(input string name, input itlb_xlate_t exp, input itlb_xlate_t act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic report_result(input string name, input int errs_before);
	test_count++;
	if (err_count == errs_before)
		$display("%s: ok", name);
	else
		$display("%s: %0d errors", name, err_count - errs_before);
endtask

// On the falling edge the inputs just sampled become the previous cycle
task automatic next_cycle();
	@(negedge clk);
	prev_adr = icpu_adr_i;
	prev_lkp = immu_en_i & icpu_cycstb_i & ~spr_req_i.cs;
endtask

// Fetch and memory outputs of the current cycle
task automatic verify_fetch();
	logic [18:0] vpn;
	logic [18:0] pvpn;
	logic [31:0] tr;
	logic        same_page;
	logic        done;
	logic        hit;
	logic        miss;
	logic        fault;
	logic        stb;
	itag_e       tag;
	itlb_xlate_t exp_x;
	itlb_xlate_t act_x;
	vpn = icpu_adr_i[31:13];
	pvpn = prev_adr[31:13];
	tr = tr_m[vpn[5:0]];
	same_page = (vpn == pvpn);
	// Lookup issued last clock on this page
	done = prev_lkp & same_page;
	hit = mr_v_m[vpn[5:0]] & (mr_tag_m[vpn[5:0]] == vpn[18:6]);
	miss = done & ~hit;
	// uxe covers user mode and sxe supervisor mode
	fault = done & hit & (supv_i ? ~tr[6] : ~tr[7]);
	if (miss)
		tag = ITAG_TE;
	else if (fault)
		tag = ITAG_PE;
	else
		tag = itag_e'(qmem_tag_i);
	stb = icpu_cycstb_i & same_page;
	if (immu_en_i)
		stb = stb & done & ~miss & ~fault;
	check_word("icpu_adr_o", prev_adr, icpu_adr_o);
	check_bit("qmem_cycstb_o", stb, qmem_cycstb_o);
	check_bit("icpu_rty_o", qmem_rty_i, icpu_rty_o);
	check_bit("icpu_err_o", miss | fault | qmem_err_i, icpu_err_o);
	check_tag("icpu_tag_o", tag, icpu_tag_o);
	if (!immu_en_i)
		check_bit("qmem_ci_o", 1'b0, qmem_ci_o);
	if (!immu_en_i || !done) begin
		// Page of the previous cycle
		check_word("qmem_adr_o", {pvpn, icpu_adr_i[12:2], 2'b00}, qmem_adr_o);
	end else if (hit) begin
		exp_x.hit = 1'b1;
		exp_x.ppn = tr[31:13];
		exp_x.uxe = tr[7];
		exp_x.sxe = tr[6];
		exp_x.ci = tr[1];
		act_x.hit = ~(icpu_err_o & (icpu_tag_o == ITAG_TE));
		act_x.ppn = qmem_adr_o[31:13];
		act_x.uxe = itlb_uxe_o;
		act_x.sxe = itlb_sxe_o;
		act_x.ci = qmem_ci_o;
		check_xlate("itlb result", exp_x, act_x);
		check_word("qmem_adr_o", {tr[31:13], icpu_adr_i[12:2], 2'b00}, qmem_adr_o);
	end
endtask

task automatic fetch_cycle(input logic en, input logic supv, input logic [31:0] adr,
		input logic stb, input logic rty, input logic err, input logic [3:0] tag);
	next_cycle();
	immu_en_i = en;
	supv_i = supv;
	icpu_adr_i = adr;
	icpu_cycstb_i = stb;
	qmem_rty_i = rty;
	qmem_err_i = err;
	qmem_tag_i = tag;
	#1;
	verify_fetch();
endtask

// mtspr holds cs for one clock
task automatic mtspr_word(input logic [31:0] addr, input logic [31:0] data);
	next_cycle();
	icpu_cycstb_i = 1'b0;
	qmem_rty_i = 1'b0;
	spr_req_i.cs = 1'b1;
	spr_req_i.write = 1'b1;
	spr_req_i.addr = addr;
	spr_req_i.wdata = data;
	// Bit 8 picks translate over match
	if (addr[8]) begin
		tr_m[addr[5:0]] = data & TR_MASK;
	end else begin
		mr_tag_m[addr[5:0]] = data[31:19];
		mr_v_m[addr[5:0]] = data[0];
	end
	next_cycle();
	spr_req_i.cs = 1'b0;
	spr_req_i.write = 1'b0;
endtask

// mfspr data comes one clock after cs and stays after cs drops
task automatic mfspr_word(input logic [31:0] addr, input logic [31:0] exp);
	next_cycle();
	icpu_cycstb_i = 1'b0;
	qmem_rty_i = 1'b0;
	spr_req_i.cs = 1'b1;
	spr_req_i.write = 1'b0;
	spr_req_i.addr = addr;
	next_cycle();
	#1;
	check_word("spr_dat_o", exp, spr_dat_o);
	next_cycle();
	spr_req_i.cs = 1'b0;
	// Lookup in another set moves the ITLB read index
	immu_en_i = 1'b1;
	icpu_cycstb_i = 1'b1;
	icpu_adr_i[18:13] = ~addr[5:0];
	#1;
	check_word("spr_dat_o held", exp, spr_dat_o);
	next_cycle();
	icpu_cycstb_i = 1'b0;
	#1;
	check_word("spr_dat_o held", exp, spr_dat_o);
endtask

function automatic logic [31:0] make_tr(input logic [18:0] ppn, input logic uxe,
		input logic sxe, input logic ci);
	return {ppn, 5'b0, uxe, sxe, 4'b0, ci, 1'b0};
endfunction

// Match and translate entry for one page
task automatic load_entry(input logic [18:0] vpn, input logic valid,
		input logic [12:0] tag_flip, input logic [31:0] tr);
	mtspr_word(MR_SPR + vpn[5:0], {vpn[18:6] ^ tag_flip, 18'h0, valid});
	mtspr_word(TR_SPR + vpn[5:0], tr);
endtask

// Translated fetches at random offsets of one page
task automatic fetch_page(input logic supv, input logic [18:0] vpn);
	logic [31:0] r;
	for (int i = 0; i < PAGE_RUN; i++) begin
		r = lcg_next();
		fetch_cycle(1'b1, supv, {vpn, r[12:0]}, 1'b1, 1'b0, 1'b0, 4'h0);
	end
endtask

task automatic boot_address_test();
	int errs;
	errs = err_count;
	// Two clocks of reset
	repeat (2) begin
		@(posedge clk);
		#1;
		check_word("icpu_adr_o", BOOT_EXP, icpu_adr_o);
	end
	next_cycle();
	dis_spr_access_frst_clk = 1'b0;
	icpu_adr_i = lcg_next();
	#1;
	check_word("icpu_adr_o", BOOT_EXP, icpu_adr_o);
	next_cycle();
	icpu_adr_i = lcg_next();
	#1;
	check_word("icpu_adr_o", BOOT_EXP, icpu_adr_o);
	check_bit("qmem_cycstb_o", 1'b0, qmem_cycstb_o);
	check_bit("icpu_err_o", 1'b0, icpu_err_o);
	check_word("spr_dat_o", 32'h0, spr_dat_o);
	// Then the fetch address one clock late
	for (int i = 0; i < BOOT_CYC - 4; i++) begin
		next_cycle();
		icpu_adr_i = lcg_next();
		#1;
		check_word("icpu_adr_o", prev_adr, icpu_adr_o);
	end
	report_result("boot address", errs);
endtask

task automatic bypass_test();
	int errs;
	logic [31:0] r;
	logic [31:0] adr;
	errs = err_count;
	adr = icpu_adr_i;
	for (int i = 0; i < BYPASS_RUN; i++) begin
		r = lcg_next();
		if (i == 0 || r[2:0] == 3'd0)
			adr = lcg_next();
		else
			adr = {adr[31:13], r[31:19]};
		fetch_cycle(1'b0, r[3], adr, r[4] | r[5], r[6] & r[7], r[8] & r[9], r[15:12]);
	end
	// Request held while memory retry stays high
	repeat (5)
		fetch_cycle(1'b0, 1'b0, adr, 1'b1, 1'b1, 1'b0, 4'h0);
	fetch_cycle(1'b0, 1'b0, adr, 1'b1, 1'b0, 1'b0, 4'h0);
	report_result("bypass", errs);
endtask

task automatic spr_access_test();
	int errs;
	logic [31:0] r;
	logic [5:0] sets [SPR_SETS];
	errs = err_count;
	for (int i = 0; i < SPR_SETS; i++) begin
		r = lcg_next();
		sets[i] = r[31:26];
		mtspr_word(MR_SPR + sets[i], lcg_next());
		mtspr_word(TR_SPR + sets[i], lcg_next());
	end
	// Only implemented bits come back
	for (int i = 0; i < SPR_SETS; i++) begin
		mfspr_word(MR_SPR + sets[i], {mr_tag_m[sets[i]], 18'h0, mr_v_m[sets[i]]});
		mfspr_word(TR_SPR + sets[i], tr_m[sets[i]]);
	end
	report_result("spr access", errs);
endtask

task automatic hit_test();
	int errs;
	logic [31:0] r;
	errs = err_count;
	r = lcg_next();
	load_entry(r[31:13], 1'b1, 13'h0, make_tr(r[18:0], 1'b1, 1'b1, r[20]));
	fetch_page(1'b0, r[31:13]);
	fetch_page(1'b1, r[31:13]);
	report_result("translation hit", errs);
endtask

task automatic miss_test();
	int errs;
	logic [31:0] r;
	errs = err_count;
	// Entry not valid
	r = lcg_next();
	load_entry(r[31:13], 1'b0, 13'h0, make_tr(r[18:0], 1'b1, 1'b1, 1'b0));
	fetch_page(1'b0, r[31:13]);
	// Valid entry with wrong tag
	r = lcg_next();
	load_entry(r[31:13], 1'b1, {r[12:1], 1'b1}, make_tr(r[18:0], 1'b1, 1'b1, 1'b0));
	fetch_page(1'b1, r[31:13]);
	report_result("tlb miss", errs);
endtask

task automatic fault_test();
	int errs;
	logic [31:0] r;
	errs = err_count;
	// No user execute
	r = lcg_next();
	load_entry(r[31:13], 1'b1, 13'h0, make_tr(r[18:0], 1'b0, 1'b1, r[20]));
	fetch_page(1'b0, r[31:13]);
	fetch_page(1'b1, r[31:13]);
	// No supervisor execute
	r = lcg_next();
	load_entry(r[31:13], 1'b1, 13'h0, make_tr(r[18:0], 1'b1, 1'b0, r[20]));
	fetch_page(1'b1, r[31:13]);
	fetch_page(1'b0, r[31:13]);
	report_result("page fault", errs);
endtask

`endif

/* bench/tb_immu_top.sv */
`timescale 1ns/100ps

module tb_immu_top;
	import immu_pkg::*;

	// Cycle budget per test
	localparam int BOOT_CYC = 12;
	localparam int BYPASS_RUN = 24;
	localparam int BYPASS_CYC = BYPASS_RUN + 6;
	localparam int SPR_SETS = 6;
	// Two writes of 2 cycles, two reads of 4 cycles per set
	localparam int SPR_CYC = SPR_SETS * 12;
	localparam int PAGE_RUN = 6;
	// Five entry loads and eight page runs over hit, miss and fault
	localparam int XLATE_CYC = 5 * 4 + 8 * PAGE_RUN;
	localparam int TIMEOUT_CYC = 2 * (BOOT_CYC + BYPASS_CYC + SPR_CYC + XLATE_CYC) + 20;
	// Reference values from the register map
	localparam logic [31:0] BOOT_EXP = 32'h0000_0100;
	localparam logic [31:0] MR_SPR = 32'h0000_1200;
	localparam logic [31:0] TR_SPR = 32'h0000_1300;
	localparam logic [31:0] TR_MASK = 32'hffff_e0c2;

	logic        clk = 1'b0;
	logic        dis_spr_access_frst_clk;
	// DUT inputs
	logic        immu_en_i;
	logic        supv_i;
	logic [31:0] icpu_adr_i;
	logic        icpu_cycstb_i;
	spr_req_t    spr_req_i;
	logic        qmem_rty_i;
	logic        qmem_err_i;
	logic [3:0]  qmem_tag_i;
	// DUT outputs
	logic [31:0] icpu_adr_o;
	itag_e       icpu_tag_o;
	logic        icpu_rty_o;
	logic        icpu_err_o;
	logic        itlb_uxe_o;
	logic        itlb_sxe_o;
	logic [31:0] spr_dat_o;
	logic [31:0] qmem_adr_o;
	logic        qmem_cycstb_o;
	logic        qmem_ci_o;

	// ITLB contents as written over SPR
	logic [12:0] mr_tag_m [64];
	logic [63:0] mr_v_m;
	logic [31:0] tr_m [64];
	// What the DUT registered at the last rising edge
	logic [31:0] prev_adr;
	logic        prev_lkp;

	logic [31:0] lcg_state = 32'hca8205ae;
	int          err_count = 0;
	int          check_count = 0;
	int          test_count = 0;
	int          cycle_count = 0;

	`include "tb_immu_tasks.svh"

	immu_top i_dut (
		.clk                     (clk),
		.dis_spr_access_frst_clk (dis_spr_access_frst_clk),
		.immu_en_i               (immu_en_i),
		.supv_i                  (supv_i),
		.icpu_adr_i              (icpu_adr_i),
		.icpu_cycstb_i           (icpu_cycstb_i),
		.icpu_adr_o              (icpu_adr_o),
		.icpu_tag_o              (icpu_tag_o),
		.icpu_rty_o              (icpu_rty_o),
		.icpu_err_o              (icpu_err_o),
		.itlb_uxe_o              (itlb_uxe_o),
		.itlb_sxe_o              (itlb_sxe_o),
		.spr_req_i               (spr_req_i),
		.spr_dat_o               (spr_dat_o),
		.qmem_rty_i              (qmem_rty_i),
		.qmem_err_i              (qmem_err_i),
		.qmem_tag_i              (qmem_tag_i),
		.qmem_adr_o              (qmem_adr_o),
		.qmem_cycstb_o           (qmem_cycstb_o),
		.qmem_ci_o               (qmem_ci_o)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYC) begin
			$display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYC);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		dis_spr_access_frst_clk = 1'b1;
		immu_en_i = 1'b0;
		supv_i = 1'b0;
		// Off the boot address, so the boot value is visible
		icpu_adr_i = 32'h0000_4000;
		icpu_cycstb_i = 1'b0;
		spr_req_i = '0;
		qmem_rty_i = 1'b0;
		qmem_err_i = 1'b0;
		qmem_tag_i = 4'h0;
		prev_adr = '0;
		prev_lkp = 1'b0;
		// Valid bits clear after reset
		mr_v_m = '0;
		for (int i = 0; i < 64; i++) begin
			mr_tag_m[i] = '0;
			tr_m[i] = '0;
		end
		boot_address_test();
		bypass_test();
		spr_access_test();
		hit_test();
		miss_test();
		fault_test();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* immu_top.f */
+incdir+bench
rtl/immu_pkg.sv
rtl/immu_itlb.sv
rtl/immu_spr_gate.sv
rtl/immu_top.sv
bench/tb_immu_top.sv

/* Bender.yml */
package:
  name: immu_top

sources:
  - rtl/immu_pkg.sv
  - rtl/immu_itlb.sv
  - rtl/immu_spr_gate.sv
  - rtl/immu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_immu_top.sv
